/* tb.f */
design/ddr3_fe_pkg.sv
design/mem_req_if.sv
design/init_sweeper.sv
design/cmd_queue.sv
design/port_sequencer.sv
design/read_return.sv
design/ddr3_front_end.sv
tests/ddr3_front_end_assertions.sv
tests/tb_ddr3_front_end.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr3_front_end \
    -f tb.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "TEST OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* tests/tb_ddr3_front_end.sv */
module tb_ddr3_front_end;
    timeunit 1ns;
    timeprecision 100ps;
    import ddr3_fe_pkg::*;

    typedef enum logic [3:0] {
        OP_HRD, OP_FWR, OP_FRD, OP_FDROP, OP_HOLD,
        OP_RELEASE, OP_READY, OP_INIT, OP_SYNC, OP_MEMCHK
    } op_e;

    typedef struct packed {
        fe_mode_e    mode;
        op_e         op;
        logic [5:0]  addr;
        logic [31:0] data;
        logic [31:0] expected;
    } row_t;

    logic afi_clk, core_rstb;
    fe_mode_e mode;
    logic host_rd_req, host_rd_ready, host_rdata_valid;
    logic [5:0] host_rd_addr;
    logic [31:0] host_rdata;
    logic flt_wvalid, flt_rvalid, flt_ready, flt_rdata_valid, init_done;
    logic [5:0] flt_addr;
    logic [31:0] flt_wdata, flt_rdata;
    logic avl_burstbegin, avl_read_req, avl_write_req;
    logic avl_ready, avl_rdata_valid;
    logic [5:0] avl_addr;
    logic [31:0] avl_wdata, avl_rdata;

    logic [31:0] mem [64];     // Memory model contents
    logic [31:0] ref_mem [64]; // Expected memory contents
    logic        cap_read;
    logic [31:0] cap_data;
    logic [2:0]  pipe_v;
    logic [31:0] pipe_d [3];
    logic        hold_ready;
    int          mem_writes;   // Writes accepted by the memory model
    int          seed = 32'hb821;

    row_t        rows[$];
    string       row_names[$];
    logic [31:0] host_expect[$];
    string       host_names[$];
    logic [31:0] flt_expect[$];
    string       flt_names[$];
    int          errors;
    int          checks;
    bit          table_built;

    ddr3_front_end i_dut (.*);

    always #50 afi_clk = ~afi_clk;

    function automatic logic [31:0] fill_word(input logic [5:0] a);
        return {8'ha5, 2'b00, a, 10'h000, a ^ 6'h15};
    endfunction

    function automatic logic [31:0] flt_word(input logic [5:0] a);
        return {16'hc0de, 2'b00, a, 2'b00, ~a};
    endfunction

    task automatic next_cycle();
        @(posedge afi_clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic add_row(input string name, input fe_mode_e m, input op_e op,
                           input int addr, input logic [31:0] data, input logic [31:0] exp);
        row_t r;
        r.mode     = m;
        r.op       = op;
        r.addr     = 6'(addr);
        r.data     = data;
        r.expected = exp;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic host_read(input string name, input logic [5:0] addr,
                             input logic [31:0] exp);
        host_rd_req  = 1'b1;
        host_rd_addr = addr;
        @(negedge afi_clk);
        while (!host_rd_ready) begin
            @(negedge afi_clk);
        end
        host_names.push_back(name); // Accepted at the coming edge
        host_expect.push_back(exp);
        next_cycle();
        host_rd_req = 1'b0;
    endtask

    task automatic filter_push(input logic write, input logic [5:0] addr,
                               input logic [31:0] data, input logic wait_ready);
        while (wait_ready && !flt_ready) begin
            next_cycle();
        end
        flt_wvalid = write;
        flt_rvalid = !write;
        flt_addr   = addr;
        flt_wdata  = data;
        next_cycle();
        flt_wvalid = 1'b0;
        flt_rvalid = 1'b0;
    endtask

    // Memory model samples the requests mid-cycle where they are settled
    always @(negedge afi_clk) begin
        cap_read = 1'b0;
        if (core_rstb && avl_ready) begin
            if (avl_write_req) begin
                mem[avl_addr] = avl_wdata;
                mem_writes++;
            end
            if (avl_read_req) begin
                cap_read = 1'b1;
                cap_data = mem[avl_addr];
            end
        end
    end

    always @(posedge afi_clk) begin
        #10;
        pipe_v    = {pipe_v[1:0], cap_read}; // 3 cycle read latency
        pipe_d[2] = pipe_d[1];
        pipe_d[1] = pipe_d[0];
        pipe_d[0] = cap_data;
        avl_rdata_valid = pipe_v[2];
        avl_rdata       = pipe_d[2];
        avl_ready       = !hold_ready && (($random(seed) & 3) != 0);
    end

    // Returned words are checked in request order on each port
    always @(negedge afi_clk) begin
        if (core_rstb && host_rdata_valid) begin
            assert (host_expect.size() != 0) else begin
                errors++;
                $display("Host port returned a word with no host read outstanding");
            end
            if (host_expect.size() != 0) begin
                check_value(host_names.pop_front(), host_expect.pop_front(), host_rdata);
            end
        end
        if (core_rstb && flt_rdata_valid) begin
            assert (flt_expect.size() != 0) else begin
                errors++;
                $display("Filter port returned a word with no filter read outstanding");
            end
            if (flt_expect.size() != 0) begin
                check_value(flt_names.pop_front(), flt_expect.pop_front(), flt_rdata);
            end
        end
    end

    initial begin
        wait (table_built);
        repeat (rows.size() * 200 + 64 * 8) @(posedge afi_clk);
        $display("Watchdog expired before all table rows completed");
        $display("Checks: %0d  errors: %0d", checks, errors + 1);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        row_t  r;
        string name;
        int    writes_at_start;
        afi_clk = 1'b0;
        core_rstb = 1'b0;
        mode = DDR3_READ;
        host_rd_req = 1'b0;
        host_rd_addr = '0;
        flt_wvalid = 1'b0;
        flt_rvalid = 1'b0;
        flt_addr = '0;
        flt_wdata = '0;
        avl_ready = 1'b0;
        avl_rdata_valid = 1'b0;
        avl_rdata = '0;
        cap_read = 1'b0;
        cap_data = '0;
        pipe_v = '0;
        hold_ready = 1'b0;
        for (int a = 0; a < 64; a++) begin
            mem[a]     = fill_word(6'(a));
            ref_mem[a] = fill_word(6'(a));
        end

        for (int a = 0; a < 8; a++) add_row("host_pattern", DDR3_READ, OP_HRD, a, 0,
                                            fill_word(6'(a)));
        for (int a = 8; a < 16; a++) add_row("flt_write", PROGRAM, OP_FWR, a,
                                             flt_word(6'(a)), 0);
        for (int a = 8; a < 16; a++) add_row("flt_readback", PROGRAM, OP_FRD, a, 0,
                                             flt_word(6'(a)));
        add_row("flt_readback", PROGRAM, OP_SYNC, 0, 0, 0);
        // Host reads still in flight when the mode moves to the filter
        for (int a = 8; a < 12; a++) add_row("switch_host", DDR3_READ, OP_HRD, a, 0,
                                             flt_word(6'(a)));
        add_row("switch_flt", CORRECTION, OP_FRD, 12, 0, flt_word(6'd12));
        add_row("switch_flt", CORRECTION, OP_FRD, 13, 0, flt_word(6'd13));
        add_row("switch_flt", CORRECTION, OP_SYNC, 0, 0, 0);
        add_row("backpressure", PROGRAM, OP_HOLD, 0, 0, 0);
        for (int a = 32; a < 44; a++) add_row("backpressure", PROGRAM, OP_FWR, a,
                                              flt_word(6'(a)), 0);
        add_row("flt_ready_low", PROGRAM, OP_READY, 0, 0, 0);
        add_row("dropped_write", PROGRAM, OP_FDROP, 44, 32'hdead_beef, 0);
        add_row("backpressure", PROGRAM, OP_RELEASE, 0, 0, 0);
        for (int a = 32; a < 44; a++) add_row("backpressure_read", PROGRAM, OP_FRD, a, 0,
                                              flt_word(6'(a)));
        add_row("dropped_write", PROGRAM, OP_FRD, 44, 0, fill_word(6'd44));
        add_row("backpressure", PROGRAM, OP_SYNC, 0, 0, 0);
        add_row("mem_after_filter", PROGRAM, OP_MEMCHK, 0, 0, 0);
        // One sweep write per memory word before init_done
        add_row("init_done", DDR3_INIT, OP_INIT, 0, 0, 64);
        for (int a = 0; a < 64; a++) add_row("init_readback", DDR3_READ, OP_HRD, a, 0, 0);
        add_row("init_readback", DDR3_READ, OP_SYNC, 0, 0, 0);
        add_row("mem_after_init", DDR3_READ, OP_MEMCHK, 0, 0, 0);
        table_built = 1'b1;

        repeat (8) @(posedge afi_clk);
        check_value("reset_outputs", 32'h1, 32'({avl_read_req, avl_write_req, avl_burstbegin,
                    host_rd_ready, host_rdata_valid, flt_rdata_valid, init_done, flt_ready}));
        repeat (8) @(posedge afi_clk);
        #10;
        core_rstb = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            r    = rows[i];
            name = row_names[i];
            if (mode != r.mode) mode = r.mode; // Sequencer drains on its own
            case (r.op)
                OP_HRD: host_read(name, r.addr, r.expected);
                OP_FWR: begin
                    filter_push(1'b1, r.addr, r.data, 1'b1);
                    ref_mem[r.addr] = r.data;
                end
                OP_FRD: begin
                    flt_names.push_back(name);
                    flt_expect.push_back(r.expected);
                    filter_push(1'b0, r.addr, '0, 1'b1);
                end
                OP_FDROP: filter_push(1'b1, r.addr, r.data, 1'b0);
                OP_HOLD: begin
                    hold_ready = 1'b1;
                    next_cycle();
                end
                OP_RELEASE: hold_ready = 1'b0;
                OP_READY: check_value(name, r.expected, 32'(flt_ready));
                OP_INIT: begin
                    writes_at_start = mem_writes;
                    while (!init_done) next_cycle();
                    check_value(name, r.expected, 32'(mem_writes - writes_at_start));
                    for (int a = 0; a < 64; a++) ref_mem[a] = '0;
                end
                OP_SYNC: begin
                    while (host_expect.size() != 0 || flt_expect.size() != 0) next_cycle();
                end
                default: begin
                    for (int a = 0; a < 64; a++) check_value(name, ref_mem[a], mem[a]);
                end
            endcase
        end

        errors += int'(i_dut.u_assertions.fail_count);
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tests/ddr3_front_end_assertions.sv */
module ddr3_front_end_assertions (
    input logic                    afi_clk,
    input logic                    core_rstb,
    input logic                    avl_burstbegin,
    input logic                    avl_read_req,
    input logic                    avl_write_req,
    input logic                    avl_ready,
    input ddr3_fe_pkg::seq_state_e seq_state
);
    timeunit 1ns;
    timeprecision 100ps;
    import ddr3_fe_pkg::*;

    int unsigned fail_count; // Read by the testbench at the end of the run

    burst_needs_accept: assert property (@(posedge afi_clk) disable iff (!core_rstb)
        avl_burstbegin |-> (avl_read_req || avl_write_req) && avl_ready)
        else begin
            fail_count++;
            $error("Burst begin was raised without a request accepted by the memory");
        end

    one_request_kind: assert property (@(posedge afi_clk) disable iff (!core_rstb)
        !(avl_read_req && avl_write_req))
        else begin
            fail_count++;
            $error("Read and write requests were raised together");
        end

    // Drain state waits for returns only
    quiet_in_drain: assert property (@(posedge afi_clk) disable iff (!core_rstb)
        seq_state == S_DRAIN |-> !avl_read_req && !avl_write_req)
        else begin
            fail_count++;
            $error("A memory request was issued while the sequencer was draining");
        end

endmodule

bind ddr3_front_end ddr3_front_end_assertions u_assertions (
    .afi_clk        (afi_clk),
    .core_rstb      (core_rstb),
    .avl_burstbegin (avl_burstbegin),
    .avl_read_req   (avl_read_req),
    .avl_write_req  (avl_write_req),
    .avl_ready      (avl_ready),
    .seq_state      (u_seq.state)
);

/* design/ddr3_front_end.sv */
module ddr3_front_end #(
    parameter int DATA_W           = ddr3_fe_pkg::DATA_W_DEF,
    parameter int ADDR_W           = ddr3_fe_pkg::ADDR_W_DEF,
    parameter int MAX_READS        = ddr3_fe_pkg::MAX_READS_DEF,
    parameter int QUEUE_DEPTH      = ddr3_fe_pkg::QUEUE_DEPTH_DEF,
    parameter int QUEUE_FULL_LEVEL = ddr3_fe_pkg::QUEUE_FULL_LEVEL_DEF
) (
    input  logic                  afi_clk,
    input  logic                  core_rstb,
    input  ddr3_fe_pkg::fe_mode_e mode,
    // Host
    input  logic                  host_rd_req,
    input  logic [ADDR_W-1:0]     host_rd_addr,
    output logic                  host_rd_ready,
    output logic [DATA_W-1:0]     host_rdata,
    output logic                  host_rdata_valid,
    // Filter
    input  logic                  flt_wvalid,
    input  logic                  flt_rvalid,
    input  logic [ADDR_W-1:0]     flt_addr,
    input  logic [DATA_W-1:0]     flt_wdata,
    output logic                  flt_ready,
    output logic [DATA_W-1:0]     flt_rdata,
    output logic                  flt_rdata_valid,
    output logic                  init_done,
    // Memory
    output logic                  avl_burstbegin,
    output logic [ADDR_W-1:0]     avl_addr,
    output logic [DATA_W-1:0]     avl_wdata,
    output logic                  avl_read_req,
    output logic                  avl_write_req,
    input  logic                  avl_ready,
    input  logic                  avl_rdata_valid,
    input  logic [DATA_W-1:0]     avl_rdata
);

    logic              sweep_en;
    logic              sweep_write;
    logic [ADDR_W-1:0] sweep_addr;
    logic              read_allowed;
    logic              reads_idle;
    logic              serving_host;
    logic              read_accepted;

    mem_req_if #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) flt_req ();

    assign read_accepted = avl_read_req & avl_ready;

    init_sweeper #(.ADDR_W(ADDR_W)) u_sweeper (
        .afi_clk     (afi_clk),
        .core_rstb   (core_rstb),
        .sweep_en    (sweep_en),
        .avl_ready   (avl_ready),
        .sweep_write (sweep_write),
        .sweep_addr  (sweep_addr),
        .init_done   (init_done)
    );

    cmd_queue #(
        .DATA_W           (DATA_W),
        .ADDR_W           (ADDR_W),
        .QUEUE_DEPTH      (QUEUE_DEPTH),
        .QUEUE_FULL_LEVEL (QUEUE_FULL_LEVEL)
    ) u_queue (
        .afi_clk    (afi_clk),
        .core_rstb  (core_rstb),
        .flt_wvalid (flt_wvalid),
        .flt_rvalid (flt_rvalid),
        .flt_addr   (flt_addr),
        .flt_wdata  (flt_wdata),
        .flt_ready  (flt_ready),
        .req        (flt_req.src)
    );

    port_sequencer #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_seq (
        .afi_clk        (afi_clk),
        .core_rstb      (core_rstb),
        .mode           (mode),
        .req            (flt_req.sink),
        .sweep_write    (sweep_write),
        .sweep_addr     (sweep_addr),
        .host_rd_req    (host_rd_req),
        .host_rd_addr   (host_rd_addr),
        .avl_ready      (avl_ready),
        .read_allowed   (read_allowed),
        .reads_idle     (reads_idle),
        .sweep_en       (sweep_en),
        .host_rd_ready  (host_rd_ready),
        .serving_host   (serving_host),
        .avl_burstbegin (avl_burstbegin),
        .avl_addr       (avl_addr),
        .avl_wdata      (avl_wdata),
        .avl_read_req   (avl_read_req),
        .avl_write_req  (avl_write_req)
    );

    read_return #(.DATA_W(DATA_W), .MAX_READS(MAX_READS)) u_ret (
        .afi_clk          (afi_clk),
        .core_rstb        (core_rstb),
        .read_accepted    (read_accepted),
        .serving_host     (serving_host),
        .avl_rdata_valid  (avl_rdata_valid),
        .avl_rdata        (avl_rdata),
        .read_allowed     (read_allowed),
        .reads_idle       (reads_idle),
        .host_rdata       (host_rdata),
        .host_rdata_valid (host_rdata_valid),
        .flt_rdata        (flt_rdata),
        .flt_rdata_valid  (flt_rdata_valid)
    );

endmodule

/* design/read_return.sv */
module read_return #(
    parameter int DATA_W    = ddr3_fe_pkg::DATA_W_DEF,
    parameter int MAX_READS = ddr3_fe_pkg::MAX_READS_DEF
) (
    input  logic              afi_clk,
    input  logic              core_rstb,
    input  logic              read_accepted,
    input  logic              serving_host,
    input  logic              avl_rdata_valid,
    input  logic [DATA_W-1:0] avl_rdata,
    output logic              read_allowed,
    output logic              reads_idle,
    output logic [DATA_W-1:0] host_rdata,
    output logic              host_rdata_valid,
    output logic [DATA_W-1:0] flt_rdata,
    output logic              flt_rdata_valid
);

    localparam int CNT_W = $clog2(MAX_READS + 1);

    logic [CNT_W-1:0] in_flight; // Reads accepted but not yet returned

    always_ff @(posedge afi_clk or negedge core_rstb) begin
        if (!core_rstb) begin
            in_flight <= '0;
        end else begin
            case ({read_accepted, avl_rdata_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: ; // Both or neither
            endcase
        end
    end

    assign read_allowed = (in_flight < CNT_W'(MAX_READS));
    assign reads_idle   = (in_flight == '0);

    // Return strobes, one cycle behind the memory
    always_ff @(posedge afi_clk or negedge core_rstb) begin
        if (!core_rstb) begin
            host_rdata_valid <= 1'b0;
            flt_rdata_valid  <= 1'b0;
        end else begin
            host_rdata_valid <= avl_rdata_valid & serving_host;
            flt_rdata_valid  <= avl_rdata_valid & ~serving_host;
        end
    end

    always_ff @(posedge afi_clk) begin
        if (avl_rdata_valid) begin
            if (serving_host) begin
                host_rdata <= avl_rdata;
            end else begin
                flt_rdata <= avl_rdata;
            end
        end
    end

endmodule

/* design/port_sequencer.sv */
module port_sequencer #(
    parameter int DATA_W = ddr3_fe_pkg::DATA_W_DEF,
    parameter int ADDR_W = ddr3_fe_pkg::ADDR_W_DEF
) (
    input  logic                 afi_clk,
    input  logic                 core_rstb,
    input  ddr3_fe_pkg::fe_mode_e mode,
    mem_req_if.sink              req,
    input  logic                 sweep_write,
    input  logic [ADDR_W-1:0]    sweep_addr,
    input  logic                 host_rd_req,
    input  logic [ADDR_W-1:0]    host_rd_addr,
    input  logic                 avl_ready,
    input  logic                 read_allowed,
    input  logic                 reads_idle,
    output logic                 sweep_en,
    output logic                 host_rd_ready,
    output logic                 serving_host,
    output logic                 avl_burstbegin,
    output logic [ADDR_W-1:0]    avl_addr,
    output logic [DATA_W-1:0]    avl_wdata,
    output logic                 avl_read_req,
    output logic                 avl_write_req
);
    import ddr3_fe_pkg::*;

    seq_state_e state;
    seq_state_e next_state;
    seq_state_e target;
    fe_mode_e   mode_q; // Mode the current state was entered for

    // State that serves each mode
    always_comb begin
        case (mode)
            DDR3_INIT:                         target = S_INIT;
            DDR3_READ:                         target = S_HOST;
            PROGRAM, SOLID_ISLANDS, CORRECTION: target = S_FILTER;
            default:                           target = S_IDLE;
        endcase
    end

    always_comb begin
        next_state = state;
        if (state == S_DRAIN) begin
            if (reads_idle) begin
                next_state = target; // Old reads all returned
            end
        end else if (mode != mode_q || (state == S_IDLE && target != S_IDLE)) begin
            next_state = S_DRAIN;
        end
    end

    always_ff @(posedge afi_clk or negedge core_rstb) begin
        if (!core_rstb) begin
            state        <= S_IDLE;
            mode_q       <= PROGRAM;
            serving_host <= 1'b0;
        end else begin
            state <= next_state;
            if (state == S_DRAIN && reads_idle) begin
                mode_q       <= mode;
                serving_host <= (target == S_HOST); // Held through the next drain
            end
        end
    end

    // Source select for the memory request lines
    always_comb begin
        avl_read_req  = 1'b0;
        avl_write_req = 1'b0;
        avl_addr      = '0;
        avl_wdata     = '0; // Sweeper writes zeros
        case (state)
            S_INIT: begin
                avl_write_req = sweep_write;
                avl_addr      = sweep_addr;
            end
            S_HOST: begin
                avl_read_req = host_rd_req & read_allowed;
                avl_addr     = host_rd_addr;
            end
            S_FILTER: begin
                avl_read_req  = req.req_valid & ~req.req_write & read_allowed;
                avl_write_req = req.req_valid & req.req_write;
                avl_addr      = req.req_addr;
                avl_wdata     = req.req_wdata;
            end
            default: ; // Idle and drain issue nothing
        endcase
    end

    assign avl_burstbegin = (avl_read_req | avl_write_req) & avl_ready;
    assign req.req_take   = (state == S_FILTER) & avl_burstbegin;
    assign sweep_en       = (state == S_INIT);
    assign host_rd_ready  = (state == S_HOST) & read_allowed & avl_ready;

endmodule

/* design/cmd_queue.sv */
module cmd_queue #(
    parameter int DATA_W           = ddr3_fe_pkg::DATA_W_DEF,
    parameter int ADDR_W           = ddr3_fe_pkg::ADDR_W_DEF,
    parameter int QUEUE_DEPTH      = ddr3_fe_pkg::QUEUE_DEPTH_DEF,
    parameter int QUEUE_FULL_LEVEL = ddr3_fe_pkg::QUEUE_FULL_LEVEL_DEF
) (
    input  logic              afi_clk,
    input  logic              core_rstb,
    input  logic              flt_wvalid,
    input  logic              flt_rvalid,
    input  logic [ADDR_W-1:0] flt_addr,
    input  logic [DATA_W-1:0] flt_wdata,
    output logic              flt_ready,
    mem_req_if.src            req
);

    localparam int ENTRY_W = 1 + ADDR_W + DATA_W; // {write, addr, data}
    localparam int PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int FILL_W  = $clog2(QUEUE_DEPTH + 1);

    logic [ENTRY_W-1:0] entries [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [FILL_W-1:0]  fill;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign flt_ready = (fill < FILL_W'(QUEUE_FULL_LEVEL));
    assign push      = (flt_wvalid | flt_rvalid) & flt_ready; // Late strobes are dropped
    assign pop       = req.req_take;

    // Head of queue
    assign req.req_valid = (fill != '0);
    assign {req.req_write, req.req_addr, req.req_wdata} = entries[rd_ptr];

    always_ff @(posedge afi_clk or negedge core_rstb) begin
        if (!core_rstb) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge afi_clk) begin
        if (push) begin
            entries[wr_ptr] <= {flt_wvalid, flt_addr, flt_wdata}; // Write wins if both strobes
        end
    end

endmodule

/* design/init_sweeper.sv */
module init_sweeper #(
    parameter int ADDR_W = ddr3_fe_pkg::ADDR_W_DEF
) (
    input  logic              afi_clk,
    input  logic              core_rstb,
    input  logic              sweep_en,
    input  logic              avl_ready,
    output logic              sweep_write,
    output logic [ADDR_W-1:0] sweep_addr,
    output logic              init_done
);

    logic [ADDR_W-1:0] addr_cnt;
    logic              accepted;

    assign sweep_write = sweep_en & ~init_done; // One write per cycle until the last word
    assign sweep_addr  = addr_cnt;
    assign accepted    = sweep_write & avl_ready;

    always_ff @(posedge afi_clk or negedge core_rstb) begin
        if (!core_rstb) begin
            addr_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!sweep_en) begin
            // Leaving init mode restarts the sweep
            addr_cnt  <= '0;
            init_done <= 1'b0;
        end else if (accepted) begin
            addr_cnt <= addr_cnt + 1'b1;
            if (addr_cnt == '1) begin
                init_done <= 1'b1; // Last word accepted
            end
        end
    end

endmodule

/* design/mem_req_if.sv */
interface mem_req_if #(
    parameter int DATA_W = ddr3_fe_pkg::DATA_W_DEF,
    parameter int ADDR_W = ddr3_fe_pkg::ADDR_W_DEF
);
    logic              req_valid;
    logic              req_write; // 1 = write, 0 = read
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              req_take;  // Entry consumed this cycle

    // Request source side
    modport src (output req_valid, req_write, req_addr, req_wdata, input req_take);

    // Sequencer side
    modport sink (input req_valid, req_write, req_addr, req_wdata, output req_take);

endinterface

/* design/ddr3_fe_pkg.sv */
package ddr3_fe_pkg;

    // Operating modes, encodings match the accelerator's mode register
    typedef enum logic [2:0] {
        PROGRAM       = 3'b000,
        SOLID_ISLANDS = 3'b001,
        CORRECTION    = 3'b010,
        DDR3_INIT     = 3'b100,
        DDR3_READ     = 3'b101
    } fe_mode_e;

    // Port sequencer states
    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_INIT   = 3'd1,
        S_HOST   = 3'd2,
        S_FILTER = 3'd3,
        S_DRAIN  = 3'd4
    } seq_state_e;

    localparam int DATA_W_DEF           = 32;
    localparam int ADDR_W_DEF           = 6;
    localparam int MAX_READS_DEF        = 12; // Reads allowed in flight
    localparam int QUEUE_DEPTH_DEF      = 16;
    localparam int QUEUE_FULL_LEVEL_DEF = 12; // Filter ready drops at this fill level

endpackage
